// ==== source/isa_pkg.sv ====
package isa_pkg;

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int REG_NUM    = 32;
	localparam int IMM_W      = 16;

	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [IMM_W-1:0]      imm_t;

	// Decoded operation, immediate forms take rt as destination
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLT  = 3'd5,
		OP_ADDI = 3'd6,
		OP_LUI  = 3'd7
	} alu_op_t;

endpackage

// ==== source/ooo_pkg.sv ====
package ooo_pkg;

	// Reorder buffer
	localparam int ROB_DEPTH = 8;
	localparam int ROB_TAG_W = $clog2(ROB_DEPTH);
	localparam int ROB_CNT_W = $clog2(ROB_DEPTH + 1);

	typedef logic [ROB_TAG_W-1:0] rob_tag_t;
	typedef logic [ROB_CNT_W-1:0] rob_cnt_t;

	// Reservation stations
	localparam int RS_DEPTH = 2;
	localparam int RS_IDX_W = $clog2(RS_DEPTH);

	typedef logic [RS_IDX_W-1:0] rs_idx_t;

endpackage

// ==== source/regfile.sv ====
module regfile (
	input  logic               clk,
	input  logic               arst_n,
	input  isa_pkg::reg_addr_t raddr_a,
	input  isa_pkg::reg_addr_t raddr_b,
	output isa_pkg::word_t     rdata_a,
	output isa_pkg::word_t     rdata_b,
	input  logic               we,
	input  isa_pkg::reg_addr_t waddr,
	input  isa_pkg::word_t     wdata
);
	import isa_pkg::*;

	word_t regs [REG_NUM];

	// Register zero is never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Write-first bypass
	always_comb begin
		rdata_a = regs[raddr_a];
		rdata_b = regs[raddr_b];
		if (we && waddr != '0 && waddr == raddr_a)
			rdata_a = wdata;
		if (we && waddr != '0 && waddr == raddr_b)
			rdata_b = wdata;
	end

endmodule

// ==== source/regfile_status.sv ====
module regfile_status (
	input  logic               clk,
	input  logic               arst_n,
	input  isa_pkg::reg_addr_t raddr_a,
	input  isa_pkg::reg_addr_t raddr_b,
	output logic               busy_a,
	output logic               busy_b,
	output ooo_pkg::rob_tag_t  tag_a,
	output ooo_pkg::rob_tag_t  tag_b,
	input  logic               status_we,
	input  isa_pkg::reg_addr_t status_waddr,
	input  ooo_pkg::rob_tag_t  status_wtag,
	input  logic               status_clr,
	input  isa_pkg::reg_addr_t clr_addr,
	input  ooo_pkg::rob_tag_t  clr_tag
);
	import isa_pkg::*;
	import ooo_pkg::*;

	logic [REG_NUM-1:0] busy;
	rob_tag_t           tags [REG_NUM];

	// Release only on matching tag, a new writer in the same cycle wins
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= '0;
		end else begin
			if (status_clr && tags[clr_addr] == clr_tag)
				busy[clr_addr] <= 1'b0;
			if (status_we && status_waddr != '0)
				busy[status_waddr] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (status_we && status_waddr != '0)
			tags[status_waddr] <= status_wtag;
	end

	assign busy_a = busy[raddr_a];
	assign busy_b = busy[raddr_b];
	assign tag_a  = tags[raddr_a];
	assign tag_b  = tags[raddr_b];

endmodule

// ==== source/rob.sv ====
module rob (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               push,
	input  isa_pkg::reg_addr_t push_rd,
	output ooo_pkg::rob_tag_t  rob_tail,
	output logic               rob_full,
	input  logic               pop,
	output logic               head_valid,
	output logic               head_done,
	output ooo_pkg::rob_tag_t  head_tag,
	output isa_pkg::reg_addr_t head_rd,
	output isa_pkg::word_t     head_data,
	input  ooo_pkg::rob_tag_t  look_tag_a,
	input  ooo_pkg::rob_tag_t  look_tag_b,
	output logic               look_done_a,
	output logic               look_done_b,
	output isa_pkg::word_t     look_data_a,
	output isa_pkg::word_t     look_data_b,
	input  logic               cdb_valid,
	input  ooo_pkg::rob_tag_t  cdb_tag,
	input  isa_pkg::word_t     cdb_data
);
	import isa_pkg::*;
	import ooo_pkg::*;

	rob_tag_t               head;
	rob_tag_t               tail;
	rob_cnt_t               count;
	logic [ROB_DEPTH-1:0]   entry_done;
	reg_addr_t              entry_rd   [ROB_DEPTH];
	word_t                  entry_data [ROB_DEPTH];

	// Pointers wrap at the power-of-two depth
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push)
				tail <= tail + rob_tag_t'(1);
			if (pop)
				head <= head + rob_tag_t'(1);
			case ({push, pop})
				2'b10:   count <= count + rob_cnt_t'(1);
				2'b01:   count <= count - rob_cnt_t'(1);
				default: count <= count;
			endcase
		end
	end

	// Done flags, set by the CDB and cleared on allocation
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			entry_done <= '0;
		end else begin
			if (cdb_valid)
				entry_done[cdb_tag] <= 1'b1;
			if (push)
				entry_done[tail] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			entry_rd[tail] <= push_rd;
		if (cdb_valid)
			entry_data[cdb_tag] <= cdb_data;
	end

	assign rob_tail   = tail;
	assign rob_full   = (count == rob_cnt_t'(ROB_DEPTH));
	assign head_valid = (count != '0);
	assign head_done  = entry_done[head];
	assign head_tag   = head;
	assign head_rd    = entry_rd[head];
	assign head_data  = entry_data[head];

	// Operand lookups for issue
	assign look_done_a = entry_done[look_tag_a];
	assign look_done_b = entry_done[look_tag_b];
	assign look_data_a = entry_data[look_tag_a];
	assign look_data_b = entry_data[look_tag_b];

endmodule

// ==== source/alu_rs.sv ====
module alu_rs (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              rs_push,
	input  isa_pkg::alu_op_t  rs_op,
	input  ooo_pkg::rob_tag_t rs_tag,
	input  isa_pkg::word_t    rs_val_a,
	input  isa_pkg::word_t    rs_val_b,
	input  logic              rs_rdy_a,
	input  logic              rs_rdy_b,
	input  ooo_pkg::rob_tag_t rs_src_a,
	input  ooo_pkg::rob_tag_t rs_src_b,
	output logic              rs_full,
	output logic              cdb_valid,
	output ooo_pkg::rob_tag_t cdb_tag,
	output isa_pkg::word_t    cdb_data
);
	import isa_pkg::*;
	import ooo_pkg::*;

	logic [RS_DEPTH-1:0] valid, rdy_a, rdy_b, ready, wake_a, wake_b;
	alu_op_t             ent_op  [RS_DEPTH];
	rob_tag_t            ent_tag [RS_DEPTH];
	rob_tag_t            src_a   [RS_DEPTH];
	rob_tag_t            src_b   [RS_DEPTH];
	word_t               val_a   [RS_DEPTH];
	word_t               val_b   [RS_DEPTH];
	rs_idx_t             older, sel_idx, push_idx, other_idx;
	logic                sel_valid;
	word_t               result;

	// Snoop own CDB for waiting operands
	always_comb begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			wake_a[i] = valid[i] & ~rdy_a[i] & cdb_valid & (cdb_tag == src_a[i]);
			wake_b[i] = valid[i] & ~rdy_b[i] & cdb_valid & (cdb_tag == src_b[i]);
			ready[i]  = valid[i] & rdy_a[i] & rdy_b[i];
		end
	end

	// Oldest ready entry first
	assign sel_valid = |ready;
	assign sel_idx   = ready[older] ? older : ~older;
	assign push_idx  = valid[0] ? rs_idx_t'(1) : rs_idx_t'(0);
	assign other_idx = ~push_idx;
	assign rs_full   = &valid;

	always_comb begin
		case (ent_op[sel_idx])
			OP_ADD, OP_ADDI: result = val_a[sel_idx] + val_b[sel_idx];
			OP_SUB:          result = val_a[sel_idx] - val_b[sel_idx];
			OP_AND:          result = val_a[sel_idx] & val_b[sel_idx];
			OP_OR:           result = val_a[sel_idx] | val_b[sel_idx];
			OP_XOR:          result = val_a[sel_idx] ^ val_b[sel_idx];
			OP_SLT:          result = word_t'($signed(val_a[sel_idx]) < $signed(val_b[sel_idx]));
			OP_LUI:          result = {val_b[sel_idx][15:0], 16'h0000};
			default:         result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid     <= '0;
			rdy_a     <= '0;
			rdy_b     <= '0;
			older     <= '0;
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= sel_valid;
			rdy_a     <= rdy_a | wake_a;
			rdy_b     <= rdy_b | wake_b;
			if (sel_valid)
				valid[sel_idx] <= 1'b0;
			if (rs_push) begin
				valid[push_idx] <= 1'b1;
				rdy_a[push_idx] <= rs_rdy_a;
				rdy_b[push_idx] <= rs_rdy_b;
				// Survivor in the other slot stays older
				if (valid[other_idx] && !(sel_valid && sel_idx == other_idx))
					older <= other_idx;
				else
					older <= push_idx;
			end else if (sel_valid) begin
				older <= ~sel_idx;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (wake_a[i])
				val_a[i] <= cdb_data;
			if (wake_b[i])
				val_b[i] <= cdb_data;
		end
		if (rs_push) begin
			ent_op[push_idx]  <= rs_op;
			ent_tag[push_idx] <= rs_tag;
			val_a[push_idx]   <= rs_val_a;
			val_b[push_idx]   <= rs_val_b;
			src_a[push_idx]   <= rs_src_a;
			src_b[push_idx]   <= rs_src_b;
		end
		cdb_tag  <= ent_tag[sel_idx];
		cdb_data <= result;
	end

endmodule

// ==== source/instr_issue.sv ====
module instr_issue (
	input  logic               instr_valid,
	input  isa_pkg::alu_op_t   instr_op,
	input  isa_pkg::reg_addr_t instr_rd,
	input  isa_pkg::reg_addr_t instr_rs,
	input  isa_pkg::reg_addr_t instr_rt,
	input  isa_pkg::imm_t      instr_imm,
	output logic               issue_stall,
	output isa_pkg::reg_addr_t reg_raddr_a,
	output isa_pkg::reg_addr_t reg_raddr_b,
	input  isa_pkg::word_t     reg_rdata_a,
	input  isa_pkg::word_t     reg_rdata_b,
	input  logic               stat_busy_a,
	input  logic               stat_busy_b,
	input  ooo_pkg::rob_tag_t  stat_tag_a,
	input  ooo_pkg::rob_tag_t  stat_tag_b,
	output logic               status_we,
	output isa_pkg::reg_addr_t status_waddr,
	output ooo_pkg::rob_tag_t  status_wtag,
	output logic               rob_push,
	output isa_pkg::reg_addr_t rob_push_rd,
	input  ooo_pkg::rob_tag_t  rob_tail,
	input  logic               rob_full,
	output ooo_pkg::rob_tag_t  look_tag_a,
	output ooo_pkg::rob_tag_t  look_tag_b,
	input  logic               look_done_a,
	input  logic               look_done_b,
	input  isa_pkg::word_t     look_data_a,
	input  isa_pkg::word_t     look_data_b,
	input  logic               cdb_valid,
	input  ooo_pkg::rob_tag_t  cdb_tag,
	input  isa_pkg::word_t     cdb_data,
	input  logic               rs_full,
	output logic               rs_push,
	output isa_pkg::alu_op_t   rs_op,
	output ooo_pkg::rob_tag_t  rs_tag,
	output isa_pkg::word_t     rs_val_a,
	output isa_pkg::word_t     rs_val_b,
	output logic               rs_rdy_a,
	output logic               rs_rdy_b,
	output ooo_pkg::rob_tag_t  rs_src_a,
	output ooo_pkg::rob_tag_t  rs_src_b
);
	import isa_pkg::*;
	import ooo_pkg::*;

	logic      accept, is_imm;
	reg_addr_t dest;
	word_t     imm_val, opnd_a, opnd_b;
	logic      opnd_rdy_a, opnd_rdy_b;

	// Register file, then ROB, then CDB, else wait on the tag
	function automatic void resolve(
		input  logic     busy,
		input  rob_tag_t tag,
		input  word_t    rf_data,
		input  logic     rob_done,
		input  word_t    rob_data,
		output word_t    val,
		output logic     rdy
	);
		rdy = 1'b1;
		if (!busy)
			val = rf_data;
		else if (rob_done)
			val = rob_data;
		else if (cdb_valid && cdb_tag == tag)
			val = cdb_data;
		else begin
			val = '0;
			rdy = 1'b0;
		end
	endfunction

	assign issue_stall = rob_full | rs_full;
	assign accept      = instr_valid & ~issue_stall;
	assign is_imm      = (instr_op == OP_ADDI) || (instr_op == OP_LUI);
	assign dest        = is_imm ? instr_rt : instr_rd;
	// LUI keeps the raw field, the ALU shifts it up
	assign imm_val     = (instr_op == OP_LUI) ? word_t'(instr_imm)
	                                          : {{16{instr_imm[15]}}, instr_imm};

	assign reg_raddr_a = instr_rs;
	assign reg_raddr_b = instr_rt;
	assign look_tag_a  = stat_tag_a;
	assign look_tag_b  = stat_tag_b;

	always_comb begin
		resolve(stat_busy_a, stat_tag_a, reg_rdata_a, look_done_a, look_data_a,
		        opnd_a, opnd_rdy_a);
		resolve(stat_busy_b, stat_tag_b, reg_rdata_b, look_done_b, look_data_b,
		        opnd_b, opnd_rdy_b);
	end

	assign rs_val_a = (instr_op == OP_LUI) ? '0 : opnd_a;
	assign rs_rdy_a = (instr_op == OP_LUI) ? 1'b1 : opnd_rdy_a;
	assign rs_val_b = is_imm ? imm_val : opnd_b;
	assign rs_rdy_b = is_imm ? 1'b1 : opnd_rdy_b;
	assign rs_src_a = stat_tag_a;
	assign rs_src_b = stat_tag_b;

	assign rs_push      = accept;
	assign rs_op        = instr_op;
	assign rs_tag       = rob_tail;
	assign rob_push     = accept;
	assign rob_push_rd  = dest;
	assign status_we    = accept;
	assign status_waddr = dest;
	assign status_wtag  = rob_tail;

endmodule

// ==== source/commit_ctrl.sv ====
module commit_ctrl (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               head_valid,
	input  logic               head_done,
	input  ooo_pkg::rob_tag_t  head_tag,
	input  isa_pkg::reg_addr_t head_rd,
	input  isa_pkg::word_t     head_data,
	output logic               rob_pop,
	output logic               reg_we,
	output isa_pkg::reg_addr_t reg_waddr,
	output isa_pkg::word_t     reg_wdata,
	output logic               status_clr,
	output isa_pkg::reg_addr_t clr_addr,
	output ooo_pkg::rob_tag_t  clr_tag,
	output logic               retire_valid,
	output isa_pkg::reg_addr_t retire_rd,
	output isa_pkg::word_t     retire_data
);

	// Retire in order, one per cycle, once the head has its result
	assign rob_pop = head_valid & head_done;

	assign reg_we    = rob_pop;
	assign reg_waddr = head_rd;
	assign reg_wdata = head_data;

	// Status entry freed only if no younger writer renamed it
	assign status_clr = rob_pop;
	assign clr_addr   = head_rd;
	assign clr_tag    = head_tag;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			retire_valid <= 1'b0;
		else
			retire_valid <= rob_pop;
	end

	always_ff @(posedge clk) begin
		if (rob_pop) begin
			retire_rd   <= head_rd;
			retire_data <= head_data;
		end
	end

endmodule

// ==== source/ooo_core.sv ====
module ooo_core (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               instr_valid,
	input  isa_pkg::alu_op_t   instr_op,
	input  isa_pkg::reg_addr_t instr_rd,
	input  isa_pkg::reg_addr_t instr_rs,
	input  isa_pkg::reg_addr_t instr_rt,
	input  isa_pkg::imm_t      instr_imm,
	output logic               issue_stall,
	output logic               retire_valid,
	output isa_pkg::reg_addr_t retire_rd,
	output isa_pkg::word_t     retire_data
);
	import isa_pkg::*;
	import ooo_pkg::*;

	// Register file
	reg_addr_t reg_raddr_a, reg_raddr_b, reg_waddr;
	word_t     reg_rdata_a, reg_rdata_b, reg_wdata;
	logic      reg_we;

	// Register status
	logic      stat_busy_a, stat_busy_b, status_we, status_clr;
	rob_tag_t  stat_tag_a, stat_tag_b, status_wtag, clr_tag;
	reg_addr_t status_waddr, clr_addr;

	// ROB
	logic      rob_push, rob_full, rob_pop, head_valid, head_done;
	logic      look_done_a, look_done_b;
	rob_tag_t  rob_tail, head_tag, look_tag_a, look_tag_b;
	reg_addr_t rob_push_rd, head_rd;
	word_t     head_data, look_data_a, look_data_b;

	// CDB and reservation stations
	logic      cdb_valid, rs_full, rs_push, rs_rdy_a, rs_rdy_b;
	rob_tag_t  cdb_tag, rs_tag, rs_src_a, rs_src_b;
	word_t     cdb_data, rs_val_a, rs_val_b;
	alu_op_t   rs_op;

	regfile regfile_inst (
		.clk,
		.arst_n,
		.raddr_a ( reg_raddr_a ),
		.raddr_b ( reg_raddr_b ),
		.rdata_a ( reg_rdata_a ),
		.rdata_b ( reg_rdata_b ),
		.we      ( reg_we      ),
		.waddr   ( reg_waddr   ),
		.wdata   ( reg_wdata   )
	);

	regfile_status regfile_status_inst (
		.clk,
		.arst_n,
		.raddr_a ( reg_raddr_a ),
		.raddr_b ( reg_raddr_b ),
		.busy_a  ( stat_busy_a ),
		.busy_b  ( stat_busy_b ),
		.tag_a   ( stat_tag_a  ),
		.tag_b   ( stat_tag_b  ),
		.status_we,
		.status_waddr,
		.status_wtag,
		.status_clr,
		.clr_addr,
		.clr_tag
	);

	rob rob_inst (
		.clk,
		.arst_n,
		.push    ( rob_push    ),
		.push_rd ( rob_push_rd ),
		.rob_tail,
		.rob_full,
		.pop     ( rob_pop     ),
		.head_valid,
		.head_done,
		.head_tag,
		.head_rd,
		.head_data,
		.look_tag_a,
		.look_tag_b,
		.look_done_a,
		.look_done_b,
		.look_data_a,
		.look_data_b,
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

	alu_rs alu_rs_inst (
		.clk,
		.arst_n,
		.rs_push,
		.rs_op,
		.rs_tag,
		.rs_val_a,
		.rs_val_b,
		.rs_rdy_a,
		.rs_rdy_b,
		.rs_src_a,
		.rs_src_b,
		.rs_full,
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

	instr_issue instr_issue_inst (
		.instr_valid,
		.instr_op,
		.instr_rd,
		.instr_rs,
		.instr_rt,
		.instr_imm,
		.issue_stall,
		.reg_raddr_a,
		.reg_raddr_b,
		.reg_rdata_a,
		.reg_rdata_b,
		.stat_busy_a,
		.stat_busy_b,
		.stat_tag_a,
		.stat_tag_b,
		.status_we,
		.status_waddr,
		.status_wtag,
		.rob_push,
		.rob_push_rd,
		.rob_tail,
		.rob_full,
		.look_tag_a,
		.look_tag_b,
		.look_done_a,
		.look_done_b,
		.look_data_a,
		.look_data_b,
		.cdb_valid,
		.cdb_tag,
		.cdb_data,
		.rs_full,
		.rs_push,
		.rs_op,
		.rs_tag,
		.rs_val_a,
		.rs_val_b,
		.rs_rdy_a,
		.rs_rdy_b,
		.rs_src_a,
		.rs_src_b
	);

	commit_ctrl commit_ctrl_inst (
		.clk,
		.arst_n,
		.head_valid,
		.head_done,
		.head_tag,
		.head_rd,
		.head_data,
		.rob_pop,
		.reg_we,
		.reg_waddr,
		.reg_wdata,
		.status_clr,
		.clr_addr,
		.clr_tag,
		.retire_valid,
		.retire_rd,
		.retire_data
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// 100 ns period
	initial begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

	// Reset held for 4 cycles, released just after an edge
	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		#5 arst_n = 1'b1;
	end

endmodule

// ==== tb/tb_ooo_core.sv ====
module tb_ooo_core;
	timeunit 1ns;
	timeprecision 1ps;
	import isa_pkg::*;

	localparam int TABLE_MAX     = 64;
	localparam int RESET_TIMEOUT = 20;
	localparam int STALL_TIMEOUT = 100;
	localparam int DRAIN_TIMEOUT = 400;

	logic      clk;
	logic      arst_n;
	logic      instr_valid;
	alu_op_t   instr_op;
	reg_addr_t instr_rd;
	reg_addr_t instr_rs;
	reg_addr_t instr_rt;
	imm_t      instr_imm;
	logic      issue_stall;
	logic      retire_valid;
	reg_addr_t retire_rd;
	word_t     retire_data;

	// Stimulus table
	alu_op_t   tbl_op  [TABLE_MAX];
	reg_addr_t tbl_rd  [TABLE_MAX];
	reg_addr_t tbl_rs  [TABLE_MAX];
	reg_addr_t tbl_rt  [TABLE_MAX];
	imm_t      tbl_imm [TABLE_MAX];
	int        tbl_len;

	// Golden in-order model
	word_t     model_regs [REG_NUM];
	reg_addr_t exp_rd_q   [$];
	word_t     exp_data_q [$];

	integer    seed;
	logic      stall_seen;

	tb_clock_gen u_clock_gen (
		.clk,
		.arst_n
	);

	ooo_core u_ooo_core (
		.clk,
		.arst_n,
		.instr_valid,
		.instr_op,
		.instr_rd,
		.instr_rs,
		.instr_rt,
		.instr_imm,
		.issue_stall,
		.retire_valid,
		.retire_rd,
		.retire_data
	);

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
	                           input logic [31:0] expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch at %0d ns: %s is 0x%h, expected 0x%h",
			                         $time, name, actual, expected));
	endtask

	task automatic add_reg_op(input alu_op_t op, input reg_addr_t rd, input reg_addr_t rs,
	                          input reg_addr_t rt);
		tbl_op[tbl_len]  = op;
		tbl_rd[tbl_len]  = rd;
		tbl_rs[tbl_len]  = rs;
		tbl_rt[tbl_len]  = rt;
		tbl_imm[tbl_len] = '0;
		tbl_len++;
	endtask

	// Immediate forms write rt
	task automatic add_imm_op(input alu_op_t op, input reg_addr_t rt, input reg_addr_t rs);
		tbl_op[tbl_len]  = op;
		tbl_rd[tbl_len]  = '0;
		tbl_rs[tbl_len]  = rs;
		tbl_rt[tbl_len]  = rt;
		tbl_imm[tbl_len] = imm_t'($random(seed));
		tbl_len++;
	endtask

	task automatic build_table();
		alu_op_t   burst_ops [6] = '{OP_ADD, OP_SUB, OP_XOR, OP_SLT, OP_OR, OP_AND};
		reg_addr_t prev;
		reg_addr_t dest;
		tbl_len = 0;
		// Independent loads
		add_imm_op(OP_ADDI, 5'd1, 5'd0);
		add_imm_op(OP_ADDI, 5'd2, 5'd0);
		add_imm_op(OP_ADDI, 5'd3, 5'd0);
		add_imm_op(OP_ADDI, 5'd4, 5'd0);
		add_imm_op(OP_LUI, 5'd5, 5'd0);
		add_imm_op(OP_LUI, 5'd6, 5'd0);
		// Write after write where the younger writer waits on r26
		// so the older one commits first, then a reader
		add_imm_op(OP_ADDI, 5'd14, 5'd0);
		add_reg_op(OP_ADD, 5'd26, 5'd14, 5'd14);
		add_imm_op(OP_ADDI, 5'd14, 5'd26);
		add_reg_op(OP_ADD, 5'd15, 5'd14, 5'd1);
		// Dependent chain
		add_reg_op(OP_ADD, 5'd7, 5'd1, 5'd2);
		add_reg_op(OP_SUB, 5'd8, 5'd7, 5'd3);
		add_reg_op(OP_SLT, 5'd9, 5'd8, 5'd7);
		add_reg_op(OP_AND, 5'd10, 5'd9, 5'd8);
		add_reg_op(OP_OR, 5'd11, 5'd10, 5'd5);
		add_reg_op(OP_XOR, 5'd12, 5'd11, 5'd7);
		add_reg_op(OP_ADD, 5'd13, 5'd12, 5'd12);
		// Register zero
		add_imm_op(OP_ADDI, 5'd0, 5'd1);
		add_reg_op(OP_ADD, 5'd0, 5'd1, 5'd2);
		add_reg_op(OP_ADD, 5'd16, 5'd0, 5'd1);
		add_reg_op(OP_OR, 5'd17, 5'd0, 5'd0);
		// Long burst of mostly dependent work
		prev = 5'd13;
		for (int k = 0; k < 24; k++) begin
			dest = reg_addr_t'(18 + (k % 8));
			if (k % 4 == 3)
				add_imm_op(OP_ADDI, dest, prev);
			else
				add_reg_op(burst_ops[k % 6], dest, prev, reg_addr_t'(1 + (k % 6)));
			prev = dest;
		end
	endtask

	function automatic word_t expected_result(input alu_op_t op, input word_t a, input word_t b,
	                                          input imm_t imm);
		word_t simm;
		simm = {{16{imm[15]}}, imm};
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_ADDI: return a + simm;
			OP_LUI:  return {imm, 16'h0000};
			default: return '0;
		endcase
	endfunction

	task automatic execute_model(input int i);
		reg_addr_t dest;
		word_t     result;
		if (tbl_op[i] == OP_ADDI || tbl_op[i] == OP_LUI)
			dest = tbl_rt[i];
		else
			dest = tbl_rd[i];
		result = expected_result(tbl_op[i], model_regs[tbl_rs[i]], model_regs[tbl_rt[i]],
		                         tbl_imm[i]);
		if (dest != '0)
			model_regs[dest] = result;
		exp_rd_q.push_back(dest);
		exp_data_q.push_back(result);
	endtask

	task automatic drive_entry(input int i);
		instr_valid = 1'b1;
		instr_op    = tbl_op[i];
		instr_rd    = tbl_rd[i];
		instr_rs    = tbl_rs[i];
		instr_rt    = tbl_rt[i];
		instr_imm   = tbl_imm[i];
	endtask

	// Hold the entry while the core stalls
	task automatic wait_not_stalled();
		int cycles;
		cycles = 0;
		while (issue_stall !== 1'b0) begin
			stall_seen = 1'b1;
			if (cycles == STALL_TIMEOUT) begin
				report_failure("timeout: issue_stall stayed high while an instruction waited");
			end else begin
				@(posedge clk);
				#5;
				cycles++;
			end
		end
	endtask

	// Retire monitor sampled away from the active edge
	always @(negedge clk) begin
		if (arst_n === 1'b1 && retire_valid !== 1'b0) begin
			if (exp_rd_q.size() == 0) begin
				report_failure("retire_valid pulsed with no instruction outstanding");
			end else begin
				check_value("retire_rd", 32'(retire_rd), 32'(exp_rd_q.pop_front()));
				check_value("retire_data", retire_data, exp_data_q.pop_front());
			end
		end
	end

	initial begin
		int cycles;
		seed        = 16403;
		stall_seen  = 1'b0;
		instr_valid = 1'b0;
		instr_op    = OP_ADD;
		instr_rd    = '0;
		instr_rs    = '0;
		instr_rt    = '0;
		instr_imm   = '0;
		for (int r = 0; r < REG_NUM; r++) begin
			model_regs[r] = '0;
		end
		build_table();

		cycles = 0;
		while (arst_n !== 1'b1) begin
			if (cycles == RESET_TIMEOUT) begin
				report_failure("timeout: reset was never released");
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
		@(posedge clk);
		#5;
		check_value("retire_valid", 32'(retire_valid), 32'd0);
		check_value("issue_stall", 32'(issue_stall), 32'd0);
		// Idle cycles where the monitor flags any retire
		repeat (6) @(posedge clk);
		#5;

		for (int i = 0; i < tbl_len; i++) begin
			drive_entry(i);
			wait_not_stalled();
			execute_model(i);
			@(posedge clk);
			#5;
		end
		instr_valid = 1'b0;
		check_value("issue_stall seen in burst", 32'(stall_seen), 32'd1);

		cycles = 0;
		while (exp_rd_q.size() != 0) begin
			if (cycles == DRAIN_TIMEOUT) begin
				report_failure("timeout: instructions did not all retire");
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
		// A few more cycles to catch extra retires
		repeat (8) @(posedge clk);

		if (exp_rd_q.size() == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			report_failure("retire queue not empty at the end of the run");
		end
	end

endmodule

// ==== verilog.f ====
source/isa_pkg.sv
source/ooo_pkg.sv
source/regfile.sv
source/regfile_status.sv
source/rob.sv
source/alu_rs.sv
source/instr_issue.sv
source/commit_ctrl.sv
source/ooo_core.sv
tb/tb_clock_gen.sv
tb/tb_ooo_core.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - source/isa_pkg.sv
  - source/ooo_pkg.sv
  - source/regfile.sv
  - source/regfile_status.sv
  - source/rob.sv
  - source/alu_rs.sv
  - source/instr_issue.sv
  - source/commit_ctrl.sv
  - source/ooo_core.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_ooo_core.sv
